// ==== cpu_bus_router.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_bus_router (
    input  logic              clock,
    input  logic              reset,
    input  logic              if_req_valid,
    input  cpu_pkg::mem_req_t if_req,
    input  logic              ls_req_valid,
    input  cpu_pkg::mem_req_t ls_req,
    input  logic              mem_req_ready,
    input  logic              mem_rsp_valid,
    input  cpu_pkg::mem_rsp_t mem_rsp,
    input  logic              console_ready,
    output logic              if_req_ready,
    output logic              if_rsp_valid,
    output logic              ls_req_ready,
    output logic              ls_rsp_valid,
    output cpu_pkg::mem_rsp_t if_rsp,
    output cpu_pkg::mem_rsp_t ls_rsp,
    output logic              mem_req_valid,
    output cpu_pkg::mem_req_t mem_req,
    output logic              console_valid,
    output logic [7:0]        console_data
);
    import cpu_pkg::*;

    mem_req_t sel_req;
    mem_rsp_t rsp;
    logic     sel_valid;
    logic     to_console;
    logic     accept;
    logic     console_wr;
    logic     pend;
    logic     owner_ls;
    logic     console_rsp;
    logic     rsp_valid;

    // load/store wins a tie
    assign sel_req    = ls_req_valid ? ls_req : if_req;
    assign sel_valid  = ls_req_valid || if_req_valid;
    assign to_console = (sel_req.addr == `CPU_CONSOLE_ADDR);
    // console takes a new request only once its byte has drained
    assign accept     = sel_valid && !pend && (to_console ? !console_valid : mem_req_ready);
    assign console_wr = accept && to_console && sel_req.write;

    assign mem_req_valid = sel_valid && !pend && !to_console;
    assign mem_req       = sel_req;
    assign ls_req_ready  = accept && ls_req_valid;
    assign if_req_ready  = accept && !ls_req_valid;

    assign rsp_valid    = pend && (console_rsp || mem_rsp_valid);
    assign rsp          = '{rdata: console_rsp ? 32'd0 : mem_rsp.rdata};
    assign ls_rsp_valid = rsp_valid && owner_ls;
    assign if_rsp_valid = rsp_valid && !owner_ls;
    assign ls_rsp       = rsp;
    assign if_rsp       = rsp;

    always_ff @(posedge clock) begin
        if (reset) begin
            pend          <= 1'b0;
            owner_ls      <= 1'b0;
            console_rsp   <= 1'b0;
            console_valid <= 1'b0;
        end else begin
            if (accept) begin
                pend        <= 1'b1;
                owner_ls    <= ls_req_valid;
                console_rsp <= to_console;
            end else if (rsp_valid) begin
                pend <= 1'b0;
            end
            if (console_wr)
                console_valid <= 1'b1;
            else if (console_ready)
                console_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (console_wr)
            console_data <= sel_req.wdata[7:0];
    end

endmodule

// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first fetch address after reset
`define CPU_RESET_PC     32'h0000_0000

// sram depth in 32-bit words
`define CPU_SRAM_WORDS   1024

// console data register
`define CPU_CONSOLE_ADDR 32'h1000_0000

`endif

// ==== cpu_decode.sv ====
`timescale 1ns/1ps

module cpu_decode (
    input  logic [31:0]   inst,
    output cpu_pkg::dec_t dec
);
    import cpu_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign funct12 = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec.rd  = inst[11:7];
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        case (funct12)
            12'h305: dec.csr = CSR_MTVEC;
            12'h341: dec.csr = CSR_MEPC;
            12'h342: dec.csr = CSR_MCAUSE;
            default: dec.csr = CSR_NONE;
        endcase
        // anything not matched below stays illegal
        dec.op  = OP_ILLEGAL;
        dec.imm = imm_i;
        case (opcode)
            7'b0110111: begin
                dec.op  = OP_LUI;
                dec.imm = imm_u;
            end
            7'b0010011: begin
                if (funct3 == 3'b000)
                    dec.op = OP_ADDI;
            end
            7'b0110011: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000)
                    dec.op = OP_ADD;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000)
                    dec.op = OP_SUB;
            end
            7'b0000011: begin
                if (funct3 == 3'b010)
                    dec.op = OP_LW;
            end
            7'b0100011: begin
                if (funct3 == 3'b010)
                    dec.op = OP_SW;
                dec.imm = imm_s;
            end
            7'b1100011: begin
                if (funct3 == 3'b000)
                    dec.op = OP_BEQ;
                dec.imm = imm_b;
            end
            7'b1101111: begin
                dec.op  = OP_JAL;
                dec.imm = imm_j;
            end
            7'b1110011: begin
                if (funct3 == 3'b001 && dec.csr != CSR_NONE)
                    dec.op = OP_CSRRW;
                else if (funct3 == 3'b000 && funct12 == 12'h000)
                    dec.op = OP_ECALL;
                else if (funct3 == 3'b000 && funct12 == 12'h001)
                    dec.op = OP_EBREAK;
                else if (funct3 == 3'b000 && funct12 == 12'h302)
                    dec.op = OP_MRET;
            end
            default: dec.op = OP_ILLEGAL;
        endcase
    end

endmodule

// ==== cpu_execute.sv ====
`timescale 1ns/1ps

module cpu_execute (
    input  logic              clock,
    input  logic              reset,
    input  logic              run,
    input  logic              fetch_done,
    input  logic [31:0]       pc,
    input  cpu_pkg::dec_t     dec,
    input  logic [31:0]       rs1_data,
    input  logic [31:0]       rs2_data,
    input  logic [31:0]       csr_rdata,
    input  logic [31:0]       mtvec,
    input  logic [31:0]       mepc,
    input  logic              req_ready,
    input  logic              rsp_valid,
    input  cpu_pkg::mem_rsp_t rsp,
    output logic              start,
    output logic [31:0]       next_pc,
    output logic              pc_we,
    output cpu_pkg::wb_t      wb,
    output logic              req_valid,
    output cpu_pkg::mem_req_t req,
    output logic              retire,
    output logic              halted
);
    import cpu_pkg::*;

    core_state_e state;
    logic        fetching;
    logic        ls_wait;
    logic        is_mem;
    logic        is_stop;
    logic        writes_rd;
    logic [31:0] result;

    assign is_mem  = (dec.op == OP_LW) || (dec.op == OP_SW);
    assign is_stop = (dec.op == OP_EBREAK) || (dec.op == OP_ILLEGAL);

    assign start     = run && (state == ST_FETCH) && !fetching;
    assign req_valid = (state == ST_MEM) && !ls_wait;
    assign retire    = ((state == ST_EXEC) && !is_mem && !is_stop)
                    || ((state == ST_MEM) && rsp_valid);
    assign pc_we     = retire;
    assign halted    = (state == ST_HALT);

    assign req = '{addr: rs1_data + dec.imm, wdata: rs2_data,
                   wstrb: (dec.op == OP_SW) ? 4'hf : 4'h0, write: dec.op == OP_SW};

    assign wb = '{we: retire && writes_rd, rd: dec.rd, data: result,
                  csr_we: retire && (dec.op == OP_CSRRW), csr: dec.csr,
                  csr_data: rs1_data, trap: retire && (dec.op == OP_ECALL)};

    always_comb begin
        result    = 32'd0;
        writes_rd = 1'b1;
        case (dec.op)
            OP_LUI:   result = dec.imm;
            OP_ADDI:  result = rs1_data + dec.imm;
            OP_ADD:   result = rs1_data + rs2_data;
            OP_SUB:   result = rs1_data - rs2_data;
            OP_LW:    result = rsp.rdata;
            OP_JAL:   result = pc + 32'd4;
            // old csr value goes to rd
            OP_CSRRW: result = csr_rdata;
            default:  writes_rd = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.op)
            OP_JAL:   next_pc = pc + dec.imm;
            OP_BEQ:   next_pc = (rs1_data == rs2_data) ? pc + dec.imm : pc + 32'd4;
            OP_ECALL: next_pc = mtvec;
            OP_MRET:  next_pc = mepc;
            default:  next_pc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ST_FETCH;
            fetching <= 1'b0;
            ls_wait  <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (start)
                        fetching <= 1'b1;
                    if (fetch_done) begin
                        fetching <= 1'b0;
                        state    <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (is_stop)
                        state <= ST_HALT;
                    else if (is_mem)
                        state <= ST_MEM;
                    else
                        state <= ST_FETCH;
                end
                ST_MEM: begin
                    if (req_valid && req_ready)
                        ls_wait <= 1'b1;
                    if (rsp_valid) begin
                        ls_wait <= 1'b0;
                        state   <= ST_FETCH;
                    end
                end
                // halt holds until reset
                default: state <= ST_HALT;
            endcase
        end
    end

endmodule

// ==== cpu_fetch.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_fetch (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  logic [31:0]       next_pc,
    input  logic              pc_we,
    input  logic              req_ready,
    input  logic              rsp_valid,
    input  cpu_pkg::mem_rsp_t rsp,
    output logic [31:0]       pc,
    output logic              req_valid,
    output cpu_pkg::mem_req_t req,
    output logic              fetch_done,
    output logic [31:0]       inst
);

    // read not yet taken by the router
    logic pend;

    assign req_valid = start || pend;
    assign req       = '{addr: pc, wdata: 32'd0, wstrb: 4'd0, write: 1'b0};

    always_ff @(posedge clock) begin
        if (reset) begin
            pc         <= `CPU_RESET_PC;
            pend       <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            pend       <= req_valid && !req_ready;
            fetch_done <= rsp_valid;
            if (pc_we)
                pc <= next_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (rsp_valid)
            inst <= rsp.rdata;
    end

endmodule

// ==== cpu_patterns.txt ====
// hex; first the test count, then per test: words bytes halt stall, program, console bytes
// stall sets the console_ready odds, ready in about one cycle out of stall+1
5
// arithmetic
0C 04 FFFFFFFF 1
100002B7 04100313 0062A023 123453B7 67838393 0072A023
00730433 0082A023 407304B3 0092A023 FFF00513 00100073
41 78 B9 C9
// memory round trip
0C 02 00000579 1
100002B7 12300313 45600393 20602023 20702223 20002403
20402483 00940533 00A2A023 008505B3 00B2A023 00100073
79 9C
// control flow
0C 03 00000020 1
100002B7 00000313 00300393 00130313 0062A023 00730463
FF5FF06F 00C000EF 05800313 0062A023 00008513 00100073
01 02 03
// trap and return
0E 02 0000005A 1
100002B7 02000313 30531073 00000073 04D00393 0072A023 05A00513
00100073 34201473 0082A023 341014F3 00448493 34149073 30200073
0B 4D
// halt and back-pressure
0D 04 00000086 20
100002B7 01000313 0062A023 01130313 0062A023 01130313 0062A023
01130313 0062A023 00630533 00100073 0062A023 00A2A023
10 21 32 43

// ==== cpu_pkg.sv ====
package cpu_pkg;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        write;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef enum logic [3:0] {
        OP_LUI, OP_ADDI, OP_ADD, OP_SUB, OP_LW, OP_SW, OP_BEQ, OP_JAL,
        OP_CSRRW, OP_ECALL, OP_MRET, OP_EBREAK, OP_ILLEGAL
    } op_e;

    typedef enum logic [1:0] {
        CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_NONE
    } csr_e;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        csr_e        csr;
    } dec_t;

    typedef enum logic [1:0] {
        ST_FETCH, ST_EXEC, ST_MEM, ST_HALT
    } core_state_e;

    // one retire worth of register and csr updates
    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        csr_we;
        csr_e        csr;
        logic [31:0] csr_data;
        logic        trap;
    } wb_t;

endpackage

// ==== cpu_regfile.sv ====
`timescale 1ns/1ps

module cpu_regfile (
    input  logic          clock,
    input  logic          reset,
    input  logic [4:0]    rs1,
    input  logic [4:0]    rs2,
    input  cpu_pkg::csr_e csr,
    input  cpu_pkg::wb_t  wb,
    input  logic [31:0]   pc,
    output logic [31:0]   rs1_data,
    output logic [31:0]   rs2_data,
    output logic [31:0]   csr_rdata,
    output logic [31:0]   mtvec,
    output logic [31:0]   mepc,
    output logic [31:0]   a0
);
    import cpu_pkg::*;

    logic [31:0] regs [32];
    logic [31:0] mcause;

    // x0 is never written
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    assign a0       = regs[10];

    always_comb begin
        case (csr)
            CSR_MTVEC:  csr_rdata = mtvec;
            CSR_MEPC:   csr_rdata = mepc;
            CSR_MCAUSE: csr_rdata = mcause;
            default:    csr_rdata = 32'd0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'd0;
            mtvec  <= 32'd0;
            mepc   <= 32'd0;
            mcause <= 32'd0;
        end else begin
            if (wb.we && wb.rd != 5'd0)
                regs[wb.rd] <= wb.data;
            if (wb.csr_we) begin
                case (wb.csr)
                    CSR_MTVEC:  mtvec  <= wb.csr_data;
                    CSR_MEPC:   mepc   <= wb.csr_data;
                    CSR_MCAUSE: mcause <= wb.csr_data;
                    default:    mtvec  <= mtvec;
                endcase
            end
            // ecall from m-mode sets mcause to 11
            if (wb.trap) begin
                mepc   <= pc;
                mcause <= 32'd11;
            end
        end
    end

endmodule

// ==== cpu_soc_top.f ====
+incdir+.
cpu_pkg.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_regfile.sv
cpu_bus_router.sv
cpu_sram.sv
cpu_soc_top.sv
cpu_soc_top_sva.sv
cpu_soc_top_tb.sv

// ==== cpu_soc_top.sv ====
`timescale 1ns/1ps

module cpu_soc_top (
    input  logic        clock,
    input  logic        reset,
    input  logic        run,
    input  logic        load_we,
    input  logic [9:0]  load_addr,
    input  logic [31:0] load_data,
    input  logic        console_ready,
    output logic        console_valid,
    output logic [7:0]  console_data,
    output logic        halted,
    output logic [31:0] halt_value
);
    import cpu_pkg::*;

    mem_req_t    if_req, ls_req, mem_req;
    mem_rsp_t    if_rsp, ls_rsp, mem_rsp;
    dec_t        dec;
    wb_t         wb;
    logic [31:0] pc, next_pc, inst;
    logic [31:0] rs1_data, rs2_data, csr_rdata, mtvec, mepc;
    logic        start, pc_we, fetch_done;
    logic        if_req_valid, if_req_ready, if_rsp_valid;
    logic        ls_req_valid, ls_req_ready, ls_rsp_valid;
    logic        mem_req_valid, mem_req_ready, mem_rsp_valid;

    cpu_fetch u_fetch (
        .clock(clock), .reset(reset), .start(start), .next_pc(next_pc), .pc_we(pc_we),
        .req_ready(if_req_ready), .rsp_valid(if_rsp_valid), .rsp(if_rsp),
        .pc(pc), .req_valid(if_req_valid), .req(if_req),
        .fetch_done(fetch_done), .inst(inst)
    );

    cpu_decode u_decode (
        .inst(inst), .dec(dec)
    );

    cpu_regfile u_regfile (
        .clock(clock), .reset(reset), .rs1(dec.rs1), .rs2(dec.rs2), .csr(dec.csr),
        .wb(wb), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .csr_rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc), .a0(halt_value)
    );

    cpu_execute u_execute (
        .clock(clock), .reset(reset), .run(run), .fetch_done(fetch_done), .pc(pc),
        .dec(dec), .rs1_data(rs1_data), .rs2_data(rs2_data), .csr_rdata(csr_rdata),
        .mtvec(mtvec), .mepc(mepc), .req_ready(ls_req_ready),
        .rsp_valid(ls_rsp_valid), .rsp(ls_rsp), .start(start), .next_pc(next_pc),
        .pc_we(pc_we), .wb(wb), .req_valid(ls_req_valid), .req(ls_req),
        .retire(), .halted(halted)
    );

    cpu_bus_router u_router (
        .clock(clock), .reset(reset), .if_req_valid(if_req_valid), .if_req(if_req),
        .ls_req_valid(ls_req_valid), .ls_req(ls_req), .mem_req_ready(mem_req_ready),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp), .console_ready(console_ready),
        .if_req_ready(if_req_ready), .if_rsp_valid(if_rsp_valid),
        .ls_req_ready(ls_req_ready), .ls_rsp_valid(ls_rsp_valid),
        .if_rsp(if_rsp), .ls_rsp(ls_rsp), .mem_req_valid(mem_req_valid),
        .mem_req(mem_req), .console_valid(console_valid), .console_data(console_data)
    );

    cpu_sram u_sram (
        .clock(clock), .reset(reset), .req_valid(mem_req_valid), .req(mem_req),
        .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
        .req_ready(mem_req_ready), .rsp_valid(mem_rsp_valid), .rsp(mem_rsp)
    );

endmodule

// ==== cpu_soc_top_sva.sv ====
`timescale 1ns/1ps

module cpu_soc_top_sva (
    input logic       clock,
    input logic       reset,
    input logic       console_valid,
    input logic       console_ready,
    input logic [7:0] console_data,
    input logic       halted
);

    // stalled byte holds until the console takes it
    console_hold: assert property (@(posedge clock) disable iff (reset)
        console_valid && !console_ready |=> console_valid && $stable(console_data))
        else $error("console byte changed while the console was stalled");

    // halt is sticky
    halt_sticky: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else $error("halted dropped without reset");

    console_reset: assert property (@(posedge clock)
        reset |=> !console_valid)
        else $error("console_valid high after a reset cycle");

endmodule

bind cpu_soc_top cpu_soc_top_sva u_sva (
    .clock(clock),
    .reset(reset),
    .console_valid(console_valid),
    .console_ready(console_ready),
    .console_data(console_data),
    .halted(halted)
);

// ==== cpu_soc_top_tb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_soc_top_tb;

    localparam int CLOCK_PERIOD    = 40;
    localparam int CYCLES_PER_TEST = 20000;
    localparam int HALT_WAIT       = 15000;
    localparam int DRAIN_CYCLES    = 40;

    logic        clock;
    logic        reset;
    logic        run;
    logic        load_we;
    logic [9:0]  load_addr;
    logic [31:0] load_data;
    logic        console_ready;
    logic        console_valid;
    logic [7:0]  console_data;
    logic        halted;
    logic [31:0] halt_value;

    logic [31:0] pat [`CPU_SRAM_WORDS];
    logic        loaded;
    integer      seed;
    int          num_tests;
    int          ptr;
    int          pass_count;
    int          fail_count;
    int          test_errors;
    int          byte_count;

    cpu_soc_top DUT (
        .clock(clock), .reset(reset), .run(run), .load_we(load_we),
        .load_addr(load_addr), .load_data(load_data), .console_ready(console_ready),
        .console_valid(console_valid), .console_data(console_data),
        .halted(halted), .halt_value(halt_value)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic reset_design();
        @(negedge clock);
        reset         = 1'b1;
        run           = 1'b0;
        load_we       = 1'b0;
        console_ready = 1'b0;
        repeat (8) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic load_program(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clock);
            load_we   = 1'b1;
            load_addr = 10'(i);
            load_data = pat[base + i];
        end
        @(negedge clock);
        load_we = 1'b0;
    endtask

    // handshake seen here completes on the next rising edge
    task automatic sample_console(input int exp_base, input int nbytes);
        logic [7:0] want;
        if (console_valid && console_ready) begin
            if (byte_count < nbytes) begin
                want = pat[exp_base + byte_count][7:0];
                if (console_data !== want) begin
                    $display("CHECK FAILED at time %0t: console_data got %02h, expected %02h",
                             $time, console_data, want);
                    test_errors++;
                end
            end else begin
                $display("unexpected console byte %02h at time %0t after all expected bytes",
                         console_data, $time);
                test_errors++;
            end
            byte_count++;
        end
    endtask

    task automatic run_test(input int num);
        int          words;
        int          nbytes;
        int          stall;
        int          cycles;
        int          exp_base;
        logic [31:0] exp_halt;
        words       = int'(pat[ptr]);
        nbytes      = int'(pat[ptr + 1]);
        exp_halt    = pat[ptr + 2];
        stall       = int'(pat[ptr + 3]);
        exp_base    = ptr + 4 + words;
        test_errors = 0;
        byte_count  = 0;
        reset_design();
        load_program(ptr + 4, words);
        run    = 1'b1;
        cycles = 0;
        while (!halted && cycles < HALT_WAIT) begin
            @(negedge clock);
            // ready in about one cycle out of stall+1
            console_ready = (($unsigned($random(seed)) % 32'(stall + 1)) == 32'd0);
            sample_console(exp_base, nbytes);
            cycles++;
        end
        if (!halted) begin
            $display("test %0d: core did not halt within %0d cycles", num, HALT_WAIT);
            test_errors++;
        end
        // last byte may still sit in the console register
        repeat (DRAIN_CYCLES) begin
            @(negedge clock);
            console_ready = 1'b1;
            sample_console(exp_base, nbytes);
        end
        if (halted && halt_value !== exp_halt) begin
            $display("CHECK FAILED at time %0t: halt_value got %08h, expected %08h",
                     $time, halt_value, exp_halt);
            test_errors++;
        end
        if (byte_count < nbytes) begin
            $display("test %0d: only %0d of %0d console bytes arrived", num, byte_count, nbytes);
            test_errors++;
        end
        run = 1'b0;
        ptr = exp_base + nbytes;
        if (test_errors == 0)
            pass_count++;
        else
            fail_count++;
        $display("test %0d %s: %0d console bytes, %0d errors", num,
                 (test_errors == 0) ? "ok" : "FAILED", byte_count, test_errors);
    endtask

    initial begin
        reset         = 1'b1;
        run           = 1'b0;
        load_we       = 1'b0;
        load_addr     = 10'd0;
        load_data     = 32'd0;
        console_ready = 1'b0;
        seed          = 32'h9a80;
        pass_count    = 0;
        fail_count    = 0;
        loaded        = 1'b0;
        $readmemh("cpu_patterns.txt", pat);
        num_tests = int'(pat[0]);
        ptr       = 1;
        loaded    = 1'b1;
        if ($isunknown(pat[0]) || num_tests == 0) begin
            $display("pattern file cpu_patterns.txt could not be read");
            fail_count++;
        end else begin
            for (int t = 1; t <= num_tests; t++)
                run_test(t);
        end
        $display("pass count %0d, fail count %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (((num_tests > 0) ? num_tests : 1) * CYCLES_PER_TEST) @(posedge clock);
        $display("watchdog expired after %0d cycles per test", CYCLES_PER_TEST);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== cpu_sram.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_sram (
    input  logic              clock,
    input  logic              reset,
    input  logic              req_valid,
    input  cpu_pkg::mem_req_t req,
    input  logic              load_we,
    input  logic [9:0]        load_addr,
    input  logic [31:0]       load_data,
    output logic              req_ready,
    output logic              rsp_valid,
    output cpu_pkg::mem_rsp_t rsp
);

    localparam int AW = $clog2(`CPU_SRAM_WORDS);

    logic [31:0]   mem [`CPU_SRAM_WORDS];
    logic [AW-1:0] idx;

    assign req_ready = 1'b1;
    assign idx       = req.addr[AW+1:2];

    always_ff @(posedge clock) begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= req_valid;
    end

    // load port only runs with the core stopped
    always_ff @(posedge clock) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end else if (req_valid && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b])
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
        if (req_valid)
            rsp.rdata <= mem[idx];
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -f cpu_soc_top.f --top-module cpu_soc_top_tb -o sim_cpu
./obj_dir/sim_cpu 2>&1 | tee sim.log
if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished without failures"
